// ==== boot_sec_top.f ====
source/soc_map_pkg.sv
source/boot_ctrl_pkg.sv
source/flush_stretcher.sv
source/code_write_guard.sv
source/mmio_ctrl_regs.sv
source/boot_policy_seq.sv
source/mpu_region_loader.sv
source/boot_sec_top.sv
verification/boot_sec_tb.sv

// ==== verification/boot_sec_tb.sv ====
// Boot security controller testbench: region load, MMIO registers, code guard, signature and lock
`default_nettype none

module boot_sec_tb
  import soc_map_pkg::*;
  import boot_ctrl_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int RESET_CYCLES  = 8;
  localparam int DONE_WAIT     = 4;
  localparam int LOCK_WAIT     = 8;
  localparam int INV_WAIT      = 2 * FLUSH_HOLD_CYCLES + 4;
  // Rough cycle length of each test
  localparam int REGION_LEN    = 20;
  localparam int ACCESS_LEN    = 24;
  localparam int GUARD_LEN     = 36;
  localparam int SIGNATURE_LEN = 52;
  localparam int LOCKED_LEN    = 48;
  localparam int TIMEOUT_CYCLES =
    2 * (2 * RESET_CYCLES + REGION_LEN + ACCESS_LEN + GUARD_LEN + SIGNATURE_LEN + LOCKED_LEN);

  logic       clk;
  logic       rst_n;
  mmio_req_t  mmio_req;
  mmio_rsp_t  mmio_rsp;
  mpu_prog_t  mpu_prog;
  logic       lock;
  logic       code_write_ok;
  logic [1:0] dc_way_mask;
  logic       ic_inv;
  logic       dc_inv;

  integer seed;
  int     err_count    = 0;
  int     tests_run    = 0;
  int     tests_failed = 0;
  int     cycle_count  = 0;
  int     en_cycles    = 0;
  int     ic_rises     = 0;
  int     dc_rises     = 0;
  logic   ic_inv_q     = 1'b0;
  logic   dc_inv_q     = 1'b0;

  // Reference model of the register state
  logic [1:0] exp_way       = 2'b11;
  logic       exp_update_en = 1'b0;
  logic       exp_wp        = 1'b0;
  logic       exp_lock      = 1'b0;

  logic reg_hit;
  logic good_sig_write;

  boot_sec_top u_boot_sec_top (
    .clk          (clk),
    .rst_n        (rst_n),
    .mmio_req     (mmio_req),
    .mmio_rsp     (mmio_rsp),
    .mpu_prog     (mpu_prog),
    .lock         (lock),
    .code_write_ok(code_write_ok),
    .dc_way_mask  (dc_way_mask),
    .ic_inv       (ic_inv),
    .dc_inv       (dc_inv)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  assign reg_hit = mmio_req.req &&
    (mmio_req.addr inside {CACHE_CTRL_ADDR, CODE_CTRL_ADDR, SIGCHECK_ADDR, LOCK_STAT_ADDR});
  assign good_sig_write = mmio_req.req && mmio_req.we && (mmio_req.addr == SIGCHECK_ADDR) &&
    (mmio_req.wdata == BOOT_SIGNATURE);

  function automatic void report_mismatch(input string name, input logic [95:0] got,
                                          input logic [95:0] exp);
    $display("Mismatch at %0d ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
    err_count++;
  endfunction

  function automatic void report_error(input string msg);
    $display("Error at %0d ns: %s", $time, msg);
    err_count++;
  endfunction

  function automatic void check_value(input string name, input logic [95:0] got,
                                      input logic [95:0] exp);
    assert (got === exp) else report_mismatch(name, got, exp);
  endfunction

  function automatic logic [31:0] code_ctrl_expected();
    logic [31:0] word;
    word = '0;
    word[UPDATE_EN_BIT] = exp_update_en;
    word[WP_SET_BIT]    = exp_wp;
    return word;
  endfunction

  // Response timing and content
  a_done_follows_hit: assert property (@(posedge clk) disable iff (!rst_n)
    reg_hit |=> mmio_rsp.done)
    else report_mismatch("mmio_rsp.done", $sampled(mmio_rsp.done), 1);
  a_no_stray_done: assert property (@(posedge clk) disable iff (!rst_n)
    !reg_hit |=> !mmio_rsp.done)
    else report_mismatch("mmio_rsp.done", $sampled(mmio_rsp.done), 0);
  a_write_reads_zero: assert property (@(posedge clk) disable iff (!rst_n)
    (reg_hit && mmio_req.we) |=> (mmio_rsp.rdata == '0))
    else report_mismatch("mmio_rsp.rdata", $sampled(mmio_rsp.rdata), 0);

  // Lock lands four edges after the edge that takes the signature
  a_lock_after_signature: assert property (@(posedge clk) disable iff (!rst_n)
    (good_sig_write && !lock) |-> !lock [*5] ##1 lock)
    else report_error("lock did not rise four edges after the signature write");

  a_ic_hold: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(ic_inv) |-> ic_inv [*FLUSH_HOLD_CYCLES] ##1 !ic_inv)
    else report_error("ic_inv was not held for the flush hold length");
  a_dc_hold: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(dc_inv) |-> dc_inv [*FLUSH_HOLD_CYCLES] ##1 !dc_inv)
    else report_error("dc_inv was not held for the flush hold length");

  // Event counters, sampled away from the active edge
  always @(negedge clk) begin
    if (mpu_prog.en) en_cycles <= en_cycles + 1;
    if (ic_inv && !ic_inv_q) ic_rises <= ic_rises + 1;
    if (dc_inv && !dc_inv_q) dc_rises <= dc_rises + 1;
    ic_inv_q <= ic_inv;
    dc_inv_q <= dc_inv;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAIL");
      $finish;
    end
  end

  // Second boot, clears the sticky write protect and the register state
  task automatic apply_reset();
    @(posedge clk);
    rst_n <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    exp_way       = 2'b11;
    exp_update_en = 1'b0;
    exp_wp        = 1'b0;
    exp_lock      = 1'b0;
  endtask

  // One request cycle, then wait a few cycles for done
  task automatic bus_access(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic done_seen);
    int waited;
    @(posedge clk);
    mmio_req <= '{req: 1'b1, we: we, addr: addr, wdata: wdata};
    @(posedge clk);
    mmio_req <= '0;
    done_seen = 1'b0;
    rdata = '0;
    waited = 0;
    while (!done_seen && waited < DONE_WAIT) begin
      @(negedge clk);
      if (mmio_rsp.done) begin
        done_seen = 1'b1;
        rdata = mmio_rsp.rdata;
      end
      waited++;
    end
  endtask

  task automatic write_reg(input logic [31:0] addr, input logic [31:0] wdata);
    logic [31:0] rdata;
    logic done_seen;
    bus_access(1'b1, addr, wdata, rdata, done_seen);
    assert (done_seen) else report_error("register write got no done");
  endtask

  task automatic read_expect(input logic [31:0] addr, input string name,
                             input logic [31:0] exp);
    logic [31:0] rdata;
    logic done_seen;
    bus_access(1'b0, addr, 32'd0, rdata, done_seen);
    assert (done_seen) else report_error("register read got no done");
    check_value(name, rdata, exp);
  endtask

  // code_write_ok is combinational, so it is checked while the request is live
  task automatic probe_code_write(input logic [31:0] addr);
    logic exp_ok;
    exp_ok = (addr >= ROM_BYTES) || !exp_wp || (exp_update_en && !exp_lock);
    @(posedge clk);
    mmio_req <= '{req: 1'b1, we: 1'b1, addr: addr, wdata: 32'h0};
    @(negedge clk);
    check_value("code_write_ok", code_write_ok, exp_ok);
    @(posedge clk);
    mmio_req <= '0;
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests_run++;
    if (err_count == errs_before) begin
      $display("[%0d ns] %s: ok", $time, name);
    end else begin
      tests_failed++;
      $display("[%0d ns] %s: failed with %0d errors", $time, name, err_count - errs_before);
    end
  endtask

  task automatic check_region_programming();
    int errs_before;
    int waited;
    int i;
    int r;
    int f;
    mpu_prog_t exp_prog;
    errs_before = err_count;
    waited = 0;
    while (!mpu_prog.en && waited < 4) begin
      @(negedge clk);
      waited++;
    end
    assert (mpu_prog.en) else report_error("region programming never started");
    for (i = 0; i < 3 * MPU_REGIONS; i++) begin
      r = i / 3;
      f = i % 3;
      exp_prog = '0;
      exp_prog.en = 1'b1;
      exp_prog.idx = 3'(r);
      exp_prog.field = mpu_field_e'(f);
      if (f == 0) exp_prog.base = REGION_BASE[r];
      if (f == 1) exp_prog.limit = REGION_LIMIT[r];
      if (f == 2) begin
        exp_prog.perm = REGION_PERM[r];
        exp_prog.user_ok = REGION_USER_OK[r];
        exp_prog.is_ispace = REGION_IS_ISPACE[r];
      end
      check_value("mpu_prog", mpu_prog, exp_prog);
      @(negedge clk);
    end
    repeat (3) begin
      check_value("mpu_prog.en", mpu_prog.en, 1'b0);
      @(negedge clk);
    end
    finish_test("region programming", errs_before);
  endtask

  task automatic check_register_access();
    int errs_before;
    logic [1:0] way;
    logic [31:0] rdata;
    logic done_seen;
    errs_before = err_count;
    way = 2'($random(seed));
    // The reset value would hide a lost write
    if (way == 2'b11) way = ~way;
    write_reg(CACHE_CTRL_ADDR, {30'd0, way});
    exp_way = way;
    read_expect(CACHE_CTRL_ADDR, "cache control readback", {30'd0, exp_way});
    check_value("dc_way_mask", dc_way_mask, exp_way);
    // Gap between registers
    bus_access(1'b0, CACHE_CTRL_ADDR + 32'h8, 32'd0, rdata, done_seen);
    assert (!done_seen) else report_error("read of an unmapped address got a done");
    bus_access(1'b1, 32'h1000_0120, 32'hFFFF_FFFF, rdata, done_seen);
    assert (!done_seen) else report_error("write to an unmapped address got a done");
    finish_test("register access", errs_before);
  endtask

  task automatic check_code_guard();
    int errs_before;
    errs_before = err_count;
    probe_code_write(32'h0000_0200);
    write_reg(CODE_CTRL_ADDR, 32'd1 << WP_SET_BIT);
    exp_wp = 1'b1;
    exp_update_en = 1'b0;
    read_expect(CODE_CTRL_ADDR, "code control readback", code_ctrl_expected());
    probe_code_write(32'h0000_0200);
    probe_code_write(ROM_BYTES - 4);
    probe_code_write(ROM_BYTES);
    probe_code_write(32'h2000_0040);
    write_reg(CODE_CTRL_ADDR, 32'd1 << UPDATE_EN_BIT);
    exp_update_en = 1'b1;
    read_expect(CODE_CTRL_ADDR, "code control readback", code_ctrl_expected());
    probe_code_write(32'h0000_0200);
    finish_test("code guard before boot", errs_before);
  endtask

  task automatic check_signature();
    int errs_before;
    int edges;
    int waited;
    int ic_before;
    int dc_before;
    logic [31:0] wrong;
    errs_before = err_count;
    apply_reset();
    wrong = $random(seed);
    if (wrong == BOOT_SIGNATURE) wrong = ~wrong;
    write_reg(SIGCHECK_ADDR, wrong);
    read_expect(SIGCHECK_ADDR, "signature check readback", 32'd0);
    read_expect(LOCK_STAT_ADDR, "lock status readback", 32'd0);
    check_value("lock", lock, 1'b0);
    // Write protect is clear here, only the sequencer can set it
    write_reg(CODE_CTRL_ADDR, 32'd1 << UPDATE_EN_BIT);
    exp_update_en = 1'b1;
    read_expect(CODE_CTRL_ADDR, "code control readback", code_ctrl_expected());
    ic_before = ic_rises;
    dc_before = dc_rises;
    write_reg(SIGCHECK_ADDR, BOOT_SIGNATURE);
    edges = 0;
    while (!lock && edges < LOCK_WAIT) begin
      @(negedge clk);
      edges++;
    end
    check_value("edges from signature write to lock", edges, 4);
    exp_lock = 1'b1;
    exp_wp = 1'b1;
    read_expect(CODE_CTRL_ADDR, "code control readback", code_ctrl_expected());
    read_expect(SIGCHECK_ADDR, "signature check readback", 32'd1);
    waited = 0;
    while ((ic_inv || dc_inv) && waited < INV_WAIT) begin
      @(negedge clk);
      waited++;
    end
    check_value("ic_inv pulses", ic_rises - ic_before, 1);
    check_value("dc_inv pulses", dc_rises - dc_before, 1);
    finish_test("signature and boot sequence", errs_before);
  endtask

  task automatic check_after_lock();
    int errs_before;
    int ic_before;
    int dc_before;
    errs_before = err_count;
    write_reg(CACHE_CTRL_ADDR, {30'd0, ~exp_way});
    read_expect(CACHE_CTRL_ADDR, "cache control readback", {30'd0, exp_way});
    check_value("dc_way_mask", dc_way_mask, exp_way);
    write_reg(CODE_CTRL_ADDR, 32'd0);
    read_expect(CODE_CTRL_ADDR, "code control readback", code_ctrl_expected());
    write_reg(SIGCHECK_ADDR, 32'd0);
    read_expect(SIGCHECK_ADDR, "signature check readback", 32'd1);
    // update_en is still set here
    probe_code_write(32'h0000_0200);
    read_expect(LOCK_STAT_ADDR, "lock status readback", 32'd1);
    ic_before = ic_rises;
    dc_before = dc_rises;
    write_reg(CACHE_CTRL_ADDR, (32'd1 << IC_FLUSH_BIT) | (32'd1 << DC_FLUSH_BIT));
    repeat (FLUSH_HOLD_CYCLES + 2) @(negedge clk);
    assert (ic_rises == ic_before && dc_rises == dc_before && !ic_inv && !dc_inv)
      else report_error("flush bit write after lock produced an invalidate");
    finish_test("behavior after lock", errs_before);
  endtask

  initial begin
    seed = 32'he153_7917;
    rst_n = 1'b0;
    mmio_req = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    check_region_programming();
    check_register_access();
    check_code_guard();
    check_signature();
    check_after_lock();
    // One region load per reset
    check_value("mpu_prog.en cycle count", en_cycles, 2 * 3 * MPU_REGIONS);
    $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, err_count);
    if (err_count == 0 && tests_failed == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== source/boot_sec_top.sv ====
// Boot security controller top: region loader, boot sequencer, MMIO registers, guard, flushes
`default_nettype none

module boot_sec_top
  import boot_ctrl_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rst_n,
  input  wire mmio_req_t mmio_req,
  output mmio_rsp_t      mmio_rsp,
  output mpu_prog_t      mpu_prog,
  output logic           lock,
  output logic           code_write_ok,
  output logic [1:0]     dc_way_mask,
  output logic           ic_inv,
  output logic           dc_inv
);

  logic sig_ok;
  logic wp_pulse;
  logic boot_flush;
  logic wp_set;
  logic wp;
  logic update_en;
  logic ic_flush_req;
  logic dc_flush_req;

  mpu_region_loader u_mpu_region_loader (
    .clk  (clk),
    .rst_n(rst_n),
    .prog (mpu_prog)
  );

  boot_policy_seq u_boot_policy_seq (
    .clk       (clk),
    .rst_n     (rst_n),
    .sig_ok    (sig_ok),
    .wp_pulse  (wp_pulse),
    .boot_flush(boot_flush),
    .lock      (lock)
  );

  mmio_ctrl_regs u_mmio_ctrl_regs (
    .clk         (clk),
    .rst_n       (rst_n),
    .req         (mmio_req),
    .rsp         (mmio_rsp),
    .lock        (lock),
    .wp          (wp),
    .boot_flush  (boot_flush),
    .sig_ok      (sig_ok),
    .wp_set      (wp_set),
    .update_en   (update_en),
    .dc_way_mask (dc_way_mask),
    .ic_flush_req(ic_flush_req),
    .dc_flush_req(dc_flush_req)
  );

  code_write_guard u_code_write_guard (
    .clk          (clk),
    .rst_n        (rst_n),
    .req          (mmio_req),
    .lock         (lock),
    .wp_pulse     (wp_pulse),
    .wp_set       (wp_set),
    .update_en    (update_en),
    .wp           (wp),
    .code_write_ok(code_write_ok)
  );

  flush_stretcher u_ic_flush (
    .clk      (clk),
    .rst_n    (rst_n),
    .flush_req(ic_flush_req),
    .inv      (ic_inv)
  );

  flush_stretcher u_dc_flush (
    .clk      (clk),
    .rst_n    (rst_n),
    .flush_req(dc_flush_req),
    .inv      (dc_inv)
  );

endmodule

`default_nettype wire

// ==== source/mpu_region_loader.sv ====
// Protection region loader: writes base, limit and permissions of each boot region after reset
`default_nettype none

module mpu_region_loader
  import soc_map_pkg::*;
  import boot_ctrl_pkg::*;
(
  input  wire logic clk,
  input  wire logic rst_n,
  output mpu_prog_t prog
);

  logic       active;
  mpu_field_e field_q;
  logic [1:0] region_q;
  mpu_prog_t  prog_d;

  // Only the field being programmed carries data
  always_comb begin
    prog_d = '0;
    if (active) begin
      prog_d.en    = 1'b1;
      prog_d.idx   = 3'(region_q);
      prog_d.field = field_q;
      case (field_q)
        BASE:  prog_d.base  = REGION_BASE[region_q];
        LIMIT: prog_d.limit = REGION_LIMIT[region_q];
        default: begin
          prog_d.perm      = REGION_PERM[region_q];
          prog_d.user_ok   = REGION_USER_OK[region_q];
          prog_d.is_ispace = REGION_IS_ISPACE[region_q];
        end
      endcase
    end
  end

  // Walks BASE, LIMIT, PERM for each region, then parks until the next reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active   <= 1'b1;
      field_q  <= BASE;
      region_q <= 2'd0;
      prog     <= '0;
    end else begin
      prog <= prog_d;
      if (active) begin
        case (field_q)
          BASE:  field_q <= LIMIT;
          LIMIT: field_q <= PERM;
          default: begin
            field_q <= BASE;
            if (region_q == 2'(MPU_REGIONS - 1)) begin
              active <= 1'b0;
            end else begin
              region_q <= region_q + 2'd1;
            end
          end
        endcase
      end
    end
  end

  // Once parked, the loader stays parked and the port stays quiet
  a_quiet_after_load: assert property (@(posedge clk) disable iff (!rst_n)
    !active |=> !active && !prog.en);

endmodule

`default_nettype wire

// ==== source/boot_policy_seq.sv ====
// Boot policy sequencer: after a good signature sets write protect, flushes caches, then locks
`default_nettype none

module boot_policy_seq
  import boot_ctrl_pkg::*;
(
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic sig_ok,
  output logic      wp_pulse,
  output logic      boot_flush,
  output logic      lock
);

  boot_phase_e phase_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase_q    <= SIG_WAIT;
      wp_pulse   <= 1'b0;
      boot_flush <= 1'b0;
      lock       <= 1'b0;
    end else begin
      wp_pulse   <= 1'b0;
      boot_flush <= 1'b0;
      case (phase_q)
        SIG_WAIT: begin
          if (sig_ok) begin
            phase_q <= SET_WP;
          end
        end
        SET_WP: begin
          wp_pulse <= 1'b1;
          phase_q  <= FLUSH;
        end
        FLUSH: begin
          // One flush of both caches
          boot_flush <= 1'b1;
          phase_q    <= LOCK;
        end
        LOCK: begin
          lock    <= 1'b1;
          phase_q <= DONE;
        end
        default: ;  // Done until reset
      endcase
    end
  end

  a_lock_sticky: assert property (@(posedge clk) disable iff (!rst_n)
    lock |=> lock);

endmodule

`default_nettype wire

// ==== source/mmio_ctrl_regs.sv ====
// MMIO control registers: cache control, code control, signature check and lock status
`default_nettype none

module mmio_ctrl_regs
  import soc_map_pkg::*;
  import boot_ctrl_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rst_n,
  input  wire mmio_req_t req,
  output mmio_rsp_t      rsp,
  input  wire logic      lock,
  input  wire logic      wp,
  input  wire logic      boot_flush,
  output logic           sig_ok,
  output logic           wp_set,
  output logic           update_en,
  output logic [1:0]     dc_way_mask,
  output logic           ic_flush_req,
  output logic           dc_flush_req
);

  logic        cache_hit;
  logic        code_hit;
  logic        sig_hit;
  logic        lock_hit;
  logic        wr_ok;
  logic [31:0] rdata_d;

  // Exact word match on each control register
  assign cache_hit = req.req && (req.addr == CACHE_CTRL_ADDR);
  assign code_hit  = req.req && (req.addr == CODE_CTRL_ADDR);
  assign sig_hit   = req.req && (req.addr == SIGCHECK_ADDR);
  assign lock_hit  = req.req && (req.addr == LOCK_STAT_ADDR);

  // Once locked, writes are answered but dropped
  assign wr_ok = req.we && !lock;

  assign wp_set = code_hit && wr_ok && req.wdata[WP_SET_BIT];

  // Flush bits self-clear, they only ever exist as a pulse
  assign ic_flush_req = boot_flush || (cache_hit && wr_ok && req.wdata[IC_FLUSH_BIT]);
  assign dc_flush_req = boot_flush || (cache_hit && wr_ok && req.wdata[DC_FLUSH_BIT]);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dc_way_mask <= 2'b11;  // Both D-cache ways enabled
      update_en   <= 1'b0;
      sig_ok      <= 1'b0;
    end else begin
      if (cache_hit && wr_ok) begin
        dc_way_mask <= req.wdata[1:0];
      end
      if (code_hit && wr_ok) begin
        update_en <= req.wdata[UPDATE_EN_BIT];
      end
      // Sticky, a wrong word never clears it
      if (sig_hit && wr_ok && (req.wdata == BOOT_SIGNATURE)) begin
        sig_ok <= 1'b1;
      end
    end
  end

  // Readback mux, writes return zero
  always_comb begin
    rdata_d = '0;
    if (!req.we) begin
      if (cache_hit) begin
        rdata_d[1:0] = dc_way_mask;
      end else if (code_hit) begin
        rdata_d[UPDATE_EN_BIT] = update_en;
        rdata_d[WP_SET_BIT]    = wp;
      end else if (sig_hit) begin
        rdata_d[0] = sig_ok;
      end else if (lock_hit) begin
        rdata_d[0] = lock;
      end
    end
  end

  // Done one cycle after any hit; misses stay silent
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp <= '0;
    end else begin
      rsp.done  <= cache_hit || code_hit || sig_hit || lock_hit;
      rsp.rdata <= rdata_d;
    end
  end

endmodule

`default_nettype wire

// ==== source/code_write_guard.sv ====
// Code write guard: sticky write protect and the allow decision for boot ROM writes
`default_nettype none

module code_write_guard
  import soc_map_pkg::*;
  import boot_ctrl_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rst_n,
  input  wire mmio_req_t req,
  input  wire logic      lock,
  input  wire logic      wp_pulse,
  input  wire logic      wp_set,
  input  wire logic      update_en,
  output logic           wp,
  output logic           code_write_ok
);

  logic code_write;

  // Only clears on reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wp <= 1'b0;
    end else if (!lock && (wp_pulse || wp_set)) begin
      wp <= 1'b1;
    end
  end

  assign code_write = req.req && req.we && (req.addr < ROM_BYTES);

  // Update enable only opens the window until lock
  assign code_write_ok = !code_write || !wp || (update_en && !lock);

endmodule

`default_nettype wire

// ==== source/flush_stretcher.sv ====
// Flush stretcher: holds a cache invalidate for a fixed number of cycles per request
`default_nettype none

module flush_stretcher
  import soc_map_pkg::*;
#(
  parameter int unsigned HOLD_CYCLES = FLUSH_HOLD_CYCLES
) (
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic flush_req,
  output logic      inv
);

  localparam int unsigned CNT_W = $clog2(HOLD_CYCLES + 1);

  logic [CNT_W-1:0] cnt;

  // A new request reloads the count
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt <= '0;
    end else if (flush_req) begin
      cnt <= CNT_W'(HOLD_CYCLES);
    end else if (cnt != '0) begin
      cnt <= cnt - 1'b1;
    end
  end

  assign inv = (cnt != '0);

  a_hold_bounded: assert property (@(posedge clk) disable iff (!rst_n)
    (inv && !flush_req) [*HOLD_CYCLES] |=> !inv);

endmodule

`default_nettype wire

// ==== source/boot_ctrl_pkg.sv ====
// Boot controller types: programming word, MMIO request and response, FSM states
`default_nettype none

package boot_ctrl_pkg;

  // Field carried by the current protection programming word
  typedef enum logic [1:0] {
    BASE,
    LIMIT,
    PERM
  } mpu_field_e;

  typedef struct packed {
    logic        en;
    logic [2:0]  idx;
    mpu_field_e  field;
    logic [31:0] base;
    logic [31:0] limit;
    logic [2:0]  perm;       // {X, W, R}
    logic        user_ok;
    logic        is_ispace;
  } mpu_prog_t;

  // One-cycle request strobe, no back-pressure
  typedef struct packed {
    logic        req;
    logic        we;
    logic [31:0] addr;
    logic [31:0] wdata;
  } mmio_req_t;

  typedef struct packed {
    logic        done;
    logic [31:0] rdata;
  } mmio_rsp_t;

  typedef enum logic [2:0] {
    SIG_WAIT,
    SET_WP,
    FLUSH,
    LOCK,
    DONE
  } boot_phase_e;

endpackage

`default_nettype wire

// ==== source/soc_map_pkg.sv ====
// SoC memory map: protection region table, MMIO register addresses and control bit positions
`default_nettype none

package soc_map_pkg;

  // Boot ROM is the code window, starting at address zero
  localparam int unsigned ROM_BYTES = 16 * 1024;

  localparam int unsigned MPU_REGIONS = 3;

  // Region table, entry 0 in the low slice; perm is {X, W, R}
  localparam logic [MPU_REGIONS-1:0][31:0] REGION_BASE = {
    32'h1000_0000,  // MMIO window
    32'h2000_0000,  // RAM
    32'h0000_0000   // Boot ROM
  };
  localparam logic [MPU_REGIONS-1:0][31:0] REGION_LIMIT = {
    32'h1000_FFFF,
    32'h2001_FFFF,
    32'h0000_FFFF
  };
  localparam logic [MPU_REGIONS-1:0][2:0] REGION_PERM = {3'b011, 3'b011, 3'b101};
  // MMIO stays supervisor only
  localparam logic [MPU_REGIONS-1:0] REGION_USER_OK   = 3'b011;
  localparam logic [MPU_REGIONS-1:0] REGION_IS_ISPACE = 3'b001;

  // Control register word addresses
  localparam logic [31:0] CACHE_CTRL_ADDR = 32'h1000_0100;
  localparam logic [31:0] CODE_CTRL_ADDR  = 32'h1000_0110;
  localparam logic [31:0] SIGCHECK_ADDR   = 32'h1000_0130;
  localparam logic [31:0] LOCK_STAT_ADDR  = 32'h1000_0140;

  localparam logic [31:0] BOOT_SIGNATURE = 32'hB007_C0DE;

  // Cache control and code control bit positions
  localparam int unsigned IC_FLUSH_BIT  = 6;
  localparam int unsigned DC_FLUSH_BIT  = 7;
  localparam int unsigned WP_SET_BIT    = 0;
  localparam int unsigned UPDATE_EN_BIT = 1;

  localparam int unsigned FLUSH_HOLD_CYCLES = 8;

endpackage

`default_nettype wire
